// ==== build.f ====
+incdir+rtl
rtl/ksBusPkg.sv
rtl/ksBusIf.sv
rtl/ksBusArb.sv
rtl/ksBusMem.sv
rtl/ksIoRegs.sv
rtl/ksBusTop.sv
tests/ksBus_assertions.sv
tests/ksBusTb.sv

// ==== rtl/ksBusArb.sv ====
// Fixed priority con > uba > cpu; a grant is held until a slave ack or the NXM timeout
`timescale 1ns/100ps
`include "ksBus_macros.svh"

module ksBusArb import ksBusPkg::*;
(
   input  logic     clk,
   input  logic     arstN,
   // Console master
   input  logic     conReq,
   input  ksBusAddr conAddr,
   input  ksWord    conWdata,
   output logic     conAck,
   output ksWord    conRdata,
   // Unibus master
   input  logic     ubaReq,
   input  ksBusAddr ubaAddr,
   input  ksWord    ubaWdata,
   output logic     ubaAck,
   output ksWord    ubaRdata,
   // CPU master
   input  logic     cpuReq,
   input  ksBusAddr cpuAddr,
   input  ksWord    cpuWdata,
   output logic     cpuAck,
   output ksWord    cpuRdata,
   // Nonexistent memory pulse
   output logic     nxm,
   // Slave ports
   ksBusIf.arb      memBus,
   ksBusIf.arb      ubaBus,
   ksBusIf.arb      conBus
);

   localparam int CntWidth = $clog2(`KS_NXM_TIMEOUT);

   ksArbState           state;         // FSM state
   ksMaster             grant;         // Registered grant
   ksMaster             nextMaster;    // Priority pick
   logic [CntWidth-1:0] nxmCount;      // Busy cycle counter
   logic                grantReq;      // Req of granted master
   ksBusAddr            selAddr;
   ksWord               selWdata;
   logic                memOk;         // Access rights of grant
   logic                ubaOk;
   logic                conOk;
   logic                slvAck;        // Permitted slave answered
   ksWord               slvRdata;
   logic                nxmTimeout;
   logic                done;          // Transfer ends this cycle

   ////////////////////////////////////////////////////////////////////////////
   // Arbitration
   ////////////////////////////////////////////////////////////////////////////

   // Console highest, CPU lowest
   always_comb
   begin
      if (conReq)
         nextMaster = MST_CON;
      else if (ubaReq)
         nextMaster = MST_UBA;
      else if (cpuReq)
         nextMaster = MST_CPU;
      else
         nextMaster = MST_NONE;
   end

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state    <= ARB_IDLE;
         grant    <= MST_NONE;
         nxmCount <= '0;
      end
      else
      begin
         case (state)
            ARB_IDLE:
            begin
               if (nextMaster != MST_NONE)
               begin
                  state    <= ARB_BUSY;
                  grant    <= nextMaster;  // Latched for whole transfer
                  nxmCount <= '0;
               end
            end
            ARB_BUSY:
            begin
               if (done)
               begin
                  state <= ARB_IDLE;
                  grant <= MST_NONE;
               end
               else
                  nxmCount <= nxmCount + 1'b1;
            end
            default:
               state <= ARB_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Request path
   ////////////////////////////////////////////////////////////////////////////

   // Mux the granted master onto the shared slave lines
   always_comb
   begin
      case (grant)
         MST_CON:
         begin
            grantReq = conReq;
            selAddr  = conAddr;
            selWdata = conWdata;
         end
         MST_UBA:
         begin
            grantReq = ubaReq;
            selAddr  = ubaAddr;
            selWdata = ubaWdata;
         end
         MST_CPU:
         begin
            grantReq = cpuReq;
            selAddr  = cpuAddr;
            selWdata = cpuWdata;
         end
         default:
         begin
            grantReq = 1'b0;
            selAddr  = '0;
            selWdata = '0;
         end
      endcase
   end

   // Everyone reaches memory
   assign memOk = (grant != MST_NONE);
   assign ubaOk = (grant == MST_CON) || (grant == MST_CPU);   // Uba itself excluded
   assign conOk = (grant == MST_CPU);                         // CPU only

   assign memBus.req   = (state == ARB_BUSY) && grantReq && memOk;
   assign ubaBus.req   = (state == ARB_BUSY) && grantReq && ubaOk;
   assign conBus.req   = (state == ARB_BUSY) && grantReq && conOk;
   assign memBus.addr  = selAddr;
   assign ubaBus.addr  = selAddr;
   assign conBus.addr  = selAddr;
   assign memBus.wdata = selWdata;
   assign ubaBus.wdata = selWdata;
   assign conBus.wdata = selWdata;

   ////////////////////////////////////////////////////////////////////////////
   // Return path and NXM
   ////////////////////////////////////////////////////////////////////////////

   // First acking slave wins
   always_comb
   begin
      slvAck   = 1'b1;
      slvRdata = '0;
      if (memBus.ack && memOk)
         slvRdata = memBus.rdata;
      else if (ubaBus.ack && ubaOk)
         slvRdata = ubaBus.rdata;
      else if (conBus.ack && conOk)
         slvRdata = conBus.rdata;
      else
         slvAck = 1'b0;
   end

   assign nxmTimeout = (state == ARB_BUSY) &&
                       (nxmCount == CntWidth'(`KS_NXM_TIMEOUT - 1));
   assign done       = (state == ARB_BUSY) && (slvAck || nxmTimeout);
   assign nxm        = nxmTimeout && !slvAck;   // Real ack beats timeout

   assign conAck   = done && (grant == MST_CON);
   assign ubaAck   = done && (grant == MST_UBA);
   assign cpuAck   = done && (grant == MST_CPU);
   assign conRdata = conAck ? slvRdata : '0;    // Zero on NXM
   assign ubaRdata = ubaAck ? slvRdata : '0;
   assign cpuRdata = cpuAck ? slvRdata : '0;

endmodule

// ==== rtl/ksBusIf.sv ====
// One arbiter-to-slave port; req is held until ack is seen and ack lasts one cycle
`timescale 1ns/100ps

interface ksBusIf import ksBusPkg::*; ();

   logic     req;                      // Request from arbiter
   ksBusAddr addr;                     // Address with flags
   ksWord    wdata;                    // Write data
   logic     ack;                      // Single-cycle acknowledge
   ksWord    rdata;                    // Read data, valid with ack

   // Arbiter side
   modport arb
   (
      output req,
      output addr,
      output wdata,
      input  ack,
      input  rdata
   );

   // Slave side
   modport slave
   (
      input  req,
      input  addr,
      input  wdata,
      output ack,
      output rdata
   );

endinterface

// ==== rtl/ksBusMem.sv ====
// Word-addressed memory below KS_MEM_DEPTH; contents are undefined after reset
`timescale 1ns/100ps
`include "ksBus_macros.svh"

module ksBusMem import ksBusPkg::*;
(
   input  logic  clk,
   input  logic  arstN,
   ksBusIf.slave bus
);

   localparam int IdxWidth = $clog2(`KS_MEM_DEPTH);

   ksWord               mem [0:`KS_MEM_DEPTH-1];
   ksWordAddr           wordAddr;
   logic [IdxWidth-1:0] idx;           // Array index
   logic                rdFlag;
   logic                wrFlag;
   logic                hit;           // Access decodes here
   logic                ackR;
   ksWord               rdataR;

   ////////////////////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////////////////////

   assign wordAddr = bus.addr[`KS_WADDR_FIRST:`KS_WADDR_LAST];
   assign idx      = wordAddr[`KS_ADDR_WIDTH-IdxWidth:`KS_ADDR_WIDTH-1];   // Low bits
   assign rdFlag   = bus.addr[`KS_READ_BIT];
   assign wrFlag   = bus.addr[`KS_WRITE_BIT];

   // Memory space only, and some access asked for
   assign hit = !bus.addr[`KS_IO_BIT] && (rdFlag || wrFlag) &&
                (wordAddr < `KS_MEM_DEPTH);

   ////////////////////////////////////////////////////////////////////////////
   // Acknowledge and storage
   ////////////////////////////////////////////////////////////////////////////

   // One cycle after req, never twice in a row
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         ackR <= 1'b0;
      else
         ackR <= bus.req && hit && !ackR;
   end

   always_ff @(posedge clk)
   begin
      if (bus.req && hit && !ackR)
         rdataR <= mem[idx];             // Old word even on read-write
      if (bus.req && hit && ackR && wrFlag)
         mem[idx] <= bus.wdata;          // Lands on the ack edge
   end

   assign bus.ack   = ackR;
   assign bus.rdata = rdataR;

endmodule

// ==== rtl/ksBusPkg.sv ====
// Shared bus types; bit 0 is the most significant bit of every vector here
`include "ksBus_macros.svh"

package ksBusPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data and address types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [0:`KS_WORD_WIDTH-1]     ksWord;      // 36-bit data word
   typedef logic [0:`KS_BUS_ADDR_WIDTH-1] ksBusAddr;   // Address plus flags
   typedef logic [0:`KS_ADDR_WIDTH-1]     ksWordAddr;  // Word address only

   ////////////////////////////////////////////////////////////////////////////
   // Arbitration types
   ////////////////////////////////////////////////////////////////////////////

   // Bus masters in no particular order
   typedef enum logic [1:0] {
      MST_NONE,                        // Nobody granted
      MST_CON,                         // Console
      MST_UBA,                         // Unibus adapter
      MST_CPU                          // Processor
   } ksMaster;

   // Arbiter FSM
   typedef enum logic {
      ARB_IDLE,                        // Waiting for a request
      ARB_BUSY                         // Transfer in flight
   } ksArbState;

endpackage

// ==== rtl/ksBusTop.sv ====
// Backplane top; masters hold req, addr and wdata stable until their ack is seen
`timescale 1ns/100ps
`include "ksBus_macros.svh"

module ksBusTop import ksBusPkg::*;
(
   input  logic     clk,
   input  logic     arstN,
   // Console master
   input  logic     conReq,
   input  ksBusAddr conAddr,
   input  ksWord    conWdata,
   output logic     conAck,
   output ksWord    conRdata,
   // Unibus master
   input  logic     ubaReq,
   input  ksBusAddr ubaAddr,
   input  ksWord    ubaWdata,
   output logic     ubaAck,
   output ksWord    ubaRdata,
   // CPU master
   input  logic     cpuReq,
   input  ksBusAddr cpuAddr,
   input  ksWord    cpuWdata,
   output logic     cpuAck,
   output ksWord    cpuRdata,
   // Nonexistent memory
   output logic     nxm
);

   ////////////////////////////////////////////////////////////////////////////
   // Slave buses
   ////////////////////////////////////////////////////////////////////////////

   ksBusIf memBus ();                  // Main memory
   ksBusIf ubaBus ();                  // Unibus registers
   ksBusIf conBus ();                  // Console registers

   ////////////////////////////////////////////////////////////////////////////
   // Arbiter and slaves
   ////////////////////////////////////////////////////////////////////////////

   ksBusArb uArb
   (
      .clk      (clk),
      .arstN    (arstN),
      .conReq   (conReq),
      .conAddr  (conAddr),
      .conWdata (conWdata),
      .conAck   (conAck),
      .conRdata (conRdata),
      .ubaReq   (ubaReq),
      .ubaAddr  (ubaAddr),
      .ubaWdata (ubaWdata),
      .ubaAck   (ubaAck),
      .ubaRdata (ubaRdata),
      .cpuReq   (cpuReq),
      .cpuAddr  (cpuAddr),
      .cpuWdata (cpuWdata),
      .cpuAck   (cpuAck),
      .cpuRdata (cpuRdata),
      .nxm      (nxm),
      .memBus   (memBus.arb),
      .ubaBus   (ubaBus.arb),
      .conBus   (conBus.arb)
   );

   ksBusMem uMem (.clk(clk), .arstN(arstN), .bus(memBus.slave));

   // Same window logic at two bases
   ksIoRegs #(.BASE(ksWordAddr'(`KS_UBA_BASE))) uUbaRegs
   (
      .clk   (clk),
      .arstN (arstN),
      .bus   (ubaBus.slave)
   );

   ksIoRegs #(.BASE(ksWordAddr'(`KS_CON_BASE))) uConRegs
   (
      .clk   (clk),
      .arstN (arstN),
      .bus   (conBus.slave)
   );

endmodule

// ==== rtl/ksBus_macros.svh ====
// Bus widths and address map; the NXM timeout and memory depth must be powers of two
`ifndef KS_BUS_MACROS_SVH
`define KS_BUS_MACROS_SVH

// Word and address widths
`define KS_WORD_WIDTH      36          // Data word
`define KS_BUS_ADDR_WIDTH  36          // Full bus address with flags
`define KS_ADDR_WIDTH      22          // Word address field
`define KS_WADDR_FIRST     14          // First bit of word address
`define KS_WADDR_LAST      35          // Last bit of word address

// Flag positions in big-endian bus address
`define KS_READ_BIT        3
`define KS_WRITE_BIT       5
`define KS_IO_BIT          6

// Address map
`define KS_MEM_DEPTH       1024        // Main memory words
`define KS_UBA_BASE        'o100       // Unibus register window
`define KS_CON_BASE        'o200       // Console register window
`define KS_IO_REGS         8           // Registers per window

// Cycles in ARB_BUSY before NXM ends a transfer
`define KS_NXM_TIMEOUT     16

`endif

// ==== rtl/ksIoRegs.sv ====
// I/O register window at BASE; window must not straddle a KS_IO_REGS boundary
`timescale 1ns/100ps
`include "ksBus_macros.svh"

module ksIoRegs import ksBusPkg::*;
#(
   parameter ksWordAddr BASE = '0      // First word address of window
)
(
   input  logic  clk,
   input  logic  arstN,
   ksBusIf.slave bus
);

   localparam int IdxWidth = $clog2(`KS_IO_REGS);

   ksWord               regs [0:`KS_IO_REGS-1];
   ksWordAddr           wordAddr;
   ksWordAddr           offset;        // Relative to BASE
   logic [IdxWidth-1:0] idx;
   logic                rdFlag;
   logic                wrFlag;
   logic                hit;
   logic                ackR;
   ksWord               rdataR;

   ////////////////////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////////////////////

   assign wordAddr = bus.addr[`KS_WADDR_FIRST:`KS_WADDR_LAST];
   assign offset   = wordAddr - BASE;
   assign idx      = offset[`KS_ADDR_WIDTH-IdxWidth:`KS_ADDR_WIDTH-1];
   assign rdFlag   = bus.addr[`KS_READ_BIT];
   assign wrFlag   = bus.addr[`KS_WRITE_BIT];

   // I/O space, inside window
   assign hit = bus.addr[`KS_IO_BIT] && (rdFlag || wrFlag) &&
                (wordAddr >= BASE) && (wordAddr < BASE + `KS_IO_REGS);

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         ackR <= 1'b0;
         for (int i = 0; i < `KS_IO_REGS; i++)
            regs[i] <= '0;               // Read back as zero
      end
      else
      begin
         ackR <= bus.req && hit && !ackR;
         if (bus.req && hit && ackR && wrFlag)
            regs[idx] <= bus.wdata;      // Write on ack edge
      end
   end

   // Read data captured with ack
   always_ff @(posedge clk)
   begin
      if (bus.req && hit && !ackR)
         rdataR <= regs[idx];
   end

   assign bus.ack   = ackR;
   assign bus.rdata = rdataR;

endmodule

// ==== tests/ksBusTb.sv ====
// Directed bus tests, LCG seed 64998; idle latency is three edges and NXM ends after 16 busy cycles
`timescale 1ns/100ps
`include "ksBus_macros.svh"

module ksBusTb import ksBusPkg::*;
();

   localparam int TimeoutCycles = 64;  // Per ack wait

   logic        clk;
   logic        arstN;
   logic        conReq, ubaReq, cpuReq;
   ksBusAddr    conAddr, ubaAddr, cpuAddr;
   ksWord       conWdata, ubaWdata, cpuWdata;
   logic        conAck, ubaAck, cpuAck;
   ksWord       conRdata, ubaRdata, cpuRdata;
   logic        nxm;

   // Reference model
   ksWord       modelMem [0:`KS_MEM_DEPTH-1];
   ksWord       modelUba [0:`KS_IO_REGS-1];
   ksWord       modelCon [0:`KS_IO_REGS-1];
   ksWordAddr   memAddrQ [$];          // Words written by CPU
   logic [31:0] lcgState;
   int          errCount;

   always #20 clk = ~clk;              // 40 ns period

   ksBusTop u_dut
   (
      .clk      (clk),
      .arstN    (arstN),
      .conReq   (conReq),
      .conAddr  (conAddr),
      .conWdata (conWdata),
      .conAck   (conAck),
      .conRdata (conRdata),
      .ubaReq   (ubaReq),
      .ubaAddr  (ubaAddr),
      .ubaWdata (ubaWdata),
      .ubaAck   (ubaAck),
      .ubaRdata (ubaRdata),
      .cpuReq   (cpuReq),
      .cpuAddr  (cpuAddr),
      .cpuWdata (cpuWdata),
      .cpuAck   (cpuAck),
      .cpuRdata (cpuRdata),
      .nxm      (nxm)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcgNext();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic ksWord randWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcgNext();
      lo = lcgNext();
      return {hi[3:0], lo};            // 36 bits
   endfunction

   // Big-endian layout, word address in bits 14..35
   function automatic ksBusAddr makeAddr(logic io, logic rd, logic wr, ksWordAddr wa);
      ksBusAddr a;
      a = '0;
      a[`KS_WADDR_FIRST:`KS_WADDR_LAST] = wa;
      a[`KS_READ_BIT]  = rd;
      a[`KS_WRITE_BIT] = wr;
      a[`KS_IO_BIT]    = io;
      return a;
   endfunction

   // Access rights of each master
   function automatic bit canReach(ksMaster m, logic io, ksWordAddr wa);
      if (!io)
         return wa < `KS_MEM_DEPTH;    // Memory for everyone
      if (wa >= `KS_UBA_BASE && wa < `KS_UBA_BASE + `KS_IO_REGS)
         return m != MST_UBA;
      if (wa >= `KS_CON_BASE && wa < `KS_CON_BASE + `KS_IO_REGS)
         return m == MST_CPU;
      return 1'b0;
   endfunction

   function automatic ksWord expectedWord(logic io, ksWordAddr wa);
      if (!io)
         return modelMem[wa];
      else if (wa < `KS_CON_BASE)
         return modelUba[wa - `KS_UBA_BASE];
      else
         return modelCon[wa - `KS_CON_BASE];
   endfunction

   function automatic void recordWrite(logic io, ksWordAddr wa, ksWord d);
      if (!io)
         modelMem[wa] = d;
      else if (wa < `KS_CON_BASE)
         modelUba[wa - `KS_UBA_BASE] = d;
      else
         modelCon[wa - `KS_CON_BASE] = d;
   endfunction

   function automatic string masterName(ksMaster m);
      case (m)
         MST_CON: return "con";
         MST_UBA: return "uba";
         default: return "cpu";
      endcase
   endfunction

   function automatic logic ackOf(ksMaster m);
      case (m)
         MST_CON: return conAck;
         MST_UBA: return ubaAck;
         default: return cpuAck;
      endcase
   endfunction

   function automatic ksWord rdataOf(ksMaster m);
      case (m)
         MST_CON: return conRdata;
         MST_UBA: return ubaRdata;
         default: return cpuRdata;
      endcase
   endfunction

   task automatic failRun(input string why);
      errCount++;
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic checkEq(input string name, input logic [63:0] exp, input logic [63:0] got);
      if (exp !== got)
         failRun($sformatf("Fail %s exp %h got %h", name, exp, got));
   endtask

   task automatic driveMaster(input ksMaster m, input logic req, input ksBusAddr a,
                              input ksWord d);
      case (m)
         MST_CON:
         begin
            conReq   = req;
            conAddr  = a;
            conWdata = d;
         end
         MST_UBA:
         begin
            ubaReq   = req;
            ubaAddr  = a;
            ubaWdata = d;
         end
         default:
         begin
            cpuReq   = req;
            cpuAddr  = a;
            cpuWdata = d;
         end
      endcase
   endtask

   // Starts and ends 2 ns after a rising edge; lat counts edges up to the ack edge
   task automatic handshake(input ksMaster m, input ksBusAddr a, input ksWord d,
                            output ksWord rd, output logic sawNxm, output int lat);
      int n;
      bit gotAck;
      n      = 0;
      gotAck = 1'b0;
      driveMaster(m, 1'b1, a, d);
      while (!gotAck && n < TimeoutCycles)
      begin
         @(negedge clk);               // Stable mid cycle
         n++;
         gotAck = ackOf(m);
      end
      if (!gotAck)
         failRun($sformatf("Timed out waiting for %s ack after %0d cycles",
                           masterName(m), TimeoutCycles));
      rd     = rdataOf(m);
      sawNxm = nxm;
      lat    = n;
      @(posedge clk);                  // Ack edge
      #2;
      driveMaster(m, 1'b0, '0, '0);
      @(posedge clk);                  // Req low for a cycle
      #2;
   endtask

   task automatic busWrite(input ksMaster m, input logic io, input ksWordAddr wa,
                           input ksWord d, output int lat);
      ksWord rd;
      logic  sawNxm;
      bit    ok;
      ok = canReach(m, io, wa);
      handshake(m, makeAddr(io, 1'b0, 1'b1, wa), d, rd, sawNxm, lat);
      checkEq("nxm", !ok, sawNxm);
      if (ok)
         recordWrite(io, wa, d);
      else
      begin
         checkEq($sformatf("%sRdata", masterName(m)), '0, rd);
         checkEq("nxmLatency", `KS_NXM_TIMEOUT + 1, lat);   // Grant plus busy cycles
      end
   endtask

   task automatic busRead(input ksMaster m, input logic io, input ksWordAddr wa,
                          output int lat);
      ksWord rd;
      ksWord exp;
      logic  sawNxm;
      bit    ok;
      ok  = canReach(m, io, wa);
      exp = ok ? expectedWord(io, wa) : '0;   // NXM reads zero
      handshake(m, makeAddr(io, 1'b1, 1'b0, wa), '0, rd, sawNxm, lat);
      checkEq("nxm", !ok, sawNxm);
      checkEq($sformatf("%sRdata", masterName(m)), exp, rd);
      if (!ok)
         checkEq("nxmLatency", `KS_NXM_TIMEOUT + 1, lat);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic resetCheck();
      int lat;
      @(negedge clk);
      checkEq("conAck", 0, conAck);
      checkEq("ubaAck", 0, ubaAck);
      checkEq("cpuAck", 0, cpuAck);
      checkEq("nxm", 0, nxm);
      checkEq("memBus.req", 0, u_dut.memBus.req);
      checkEq("ubaBus.req", 0, u_dut.ubaBus.req);
      checkEq("conBus.req", 0, u_dut.conBus.req);
      @(posedge clk);
      #2;
      busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_UBA_BASE), lat);   // Cleared registers
      busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_CON_BASE + `KS_IO_REGS - 1), lat);
   endtask

   task automatic memoryReadWrite();
      ksWordAddr wa;
      int        lat;
      repeat (32)
      begin
         wa = ksWordAddr'(lcgNext() % `KS_MEM_DEPTH);
         busWrite(MST_CPU, 1'b0, wa, randWord(), lat);
         checkEq("cpuWriteLatency", 3, lat);   // Grant, slave, ack
         memAddrQ.push_back(wa);
      end
      foreach (memAddrQ[i])
      begin
         busRead(MST_CPU, 1'b0, memAddrQ[i], lat);
         checkEq("cpuReadLatency", 3, lat);
      end
   endtask

   task automatic priorityOrder();
      int conLat;
      int cpuLat;
      fork
         busRead(MST_CON, 1'b0, memAddrQ[0], conLat);
         busRead(MST_CPU, 1'b0, memAddrQ[$], cpuLat);
      join
      checkEq("conLatency", 3, conLat);    // Console wins outright
      if (cpuLat <= conLat)
         failRun("CPU ack did not come after the console ack");
   endtask

   task automatic ioWindows();
      int lat;
      for (int i = 0; i < `KS_IO_REGS; i++)
      begin
         busWrite(MST_CPU, 1'b1, ksWordAddr'(`KS_UBA_BASE + i), randWord(), lat);
         busWrite(MST_CPU, 1'b1, ksWordAddr'(`KS_CON_BASE + i), randWord(), lat);
      end
      for (int i = 0; i < `KS_IO_REGS; i++)
      begin
         busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_UBA_BASE + i), lat);
         busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_CON_BASE + i), lat);
      end
      // Console into every other Unibus register
      for (int i = 0; i < `KS_IO_REGS; i += 2)
      begin
         busWrite(MST_CON, 1'b1, ksWordAddr'(`KS_UBA_BASE + i), randWord(), lat);
         busRead(MST_CON, 1'b1, ksWordAddr'(`KS_UBA_BASE + i), lat);
      end
      for (int i = 0; i < `KS_IO_REGS; i++)
         busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_UBA_BASE + i), lat);
   endtask

   task automatic accessRights();
      int lat;
      // Unibus master reaches memory
      busWrite(MST_UBA, 1'b0, memAddrQ[1], randWord(), lat);
      busRead(MST_UBA, 1'b0, memAddrQ[1], lat);
      // Unibus master has no I/O rights
      busWrite(MST_UBA, 1'b1, ksWordAddr'(`KS_UBA_BASE + 2), randWord(), lat);
      busRead(MST_UBA, 1'b1, ksWordAddr'(`KS_UBA_BASE + 2), lat);
      busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_UBA_BASE + 2), lat);   // Unchanged
      // Console window is CPU only
      busWrite(MST_CON, 1'b1, ksWordAddr'(`KS_CON_BASE + 3), randWord(), lat);
      busRead(MST_CON, 1'b1, ksWordAddr'(`KS_CON_BASE + 3), lat);
      busRead(MST_CPU, 1'b1, ksWordAddr'(`KS_CON_BASE + 3), lat);
      // Beyond memory, same low bits as a stored word
      busWrite(MST_CPU, 1'b0, ksWordAddr'(`KS_MEM_DEPTH) + memAddrQ[0], randWord(), lat);
      busRead(MST_UBA, 1'b0, ksWordAddr'(3 * `KS_MEM_DEPTH) + memAddrQ[0], lat);
      busRead(MST_CON, 1'b0, '1, lat);    // Top of address space
      busRead(MST_CPU, 1'b0, memAddrQ[0], lat);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk      = 1'b0;
      arstN    = 1'b0;
      lcgState = 32'd64998;
      errCount = 0;
      driveMaster(MST_CON, 1'b0, '0, '0);
      driveMaster(MST_UBA, 1'b0, '0, '0);
      driveMaster(MST_CPU, 1'b0, '0, '0);
      for (int i = 0; i < `KS_IO_REGS; i++)
      begin
         modelUba[i] = '0;
         modelCon[i] = '0;
      end
      repeat (8) @(posedge clk);       // Reset for 8 cycles
      #2;
      arstN = 1'b1;

      resetCheck();
      memoryReadWrite();
      priorityOrder();
      ioWindows();
      accessRights();

      if (errCount == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
         failRun("One or more checks failed");
   end

endmodule

// ==== tests/ksBus_assertions.sv ====
// Arbiter handshake checks bound into ksBusArb; reset low disables all checks
`timescale 1ns/100ps

module ksBusAssertions import ksBusPkg::*;
(
   input logic      clk,
   input logic      arstN,
   input logic      conAck,
   input logic      ubaAck,
   input logic      cpuAck,
   input logic      memSlvAck,
   input logic      ubaSlvAck,
   input logic      conSlvAck,
   input logic      nxm,
   input ksArbState state,
   input ksMaster   grant
);

   logic anyAck;                       // Some master finishing

   assign anyAck = conAck || ubaAck || cpuAck;

   ////////////////////////////////////////////////////////////////////////////
   // Handshake properties
   ////////////////////////////////////////////////////////////////////////////

   // One master finishes at a time, and only one slave answers
   onlyOneAck: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0({conAck, ubaAck, cpuAck}) && $onehot0({memSlvAck, ubaSlvAck, conSlvAck}))
      else $error("More than one ack high in the same cycle");

   // No stealing mid transfer
   grantHeld: assert property (@(posedge clk) disable iff (!arstN)
      (state == ARB_BUSY && !anyAck && !nxm) |=> (grant == $past(grant)))
      else $error("Grant changed while a transfer was in flight");

   ackSingleCycle: assert property (@(posedge clk) disable iff (!arstN)
      anyAck |=> !anyAck)
      else $error("Master ack held high for two cycles");

endmodule

bind ksBusArb ksBusAssertions uArbAsserts
(
   .clk       (clk),
   .arstN     (arstN),
   .conAck    (conAck),
   .ubaAck    (ubaAck),
   .cpuAck    (cpuAck),
   .memSlvAck (memBus.ack),
   .ubaSlvAck (ubaBus.ack),
   .conSlvAck (conBus.ack),
   .nxm       (nxm),
   .state     (state),
   .grant     (grant)
);
